// File: logic/lsu_params_pkg.sv
/* word, tag and queue widths for the load/store unit,
   plus the default queue depths */
package lsu_params_pkg;

	// word-addressed data memory
	localparam int unsigned ADDR_W = 6;
	localparam int unsigned DATA_W = 32;

	// destination register tag
	localparam int unsigned TAG_W = 5;

	// default depths, overridden from the top
	localparam int unsigned SQ_DEPTH_DEF = 8;
	localparam int unsigned LQ_DEPTH_DEF = 4;

	// store-queue pointer with wrap bit, used as load position
	localparam int unsigned SQ_PTR_W = $clog2(SQ_DEPTH_DEF) + 1;

endpackage

// File: logic/lsu_types_pkg.sv
/* command opcodes, load-queue entry states
   and the decoded store command */
package lsu_types_pkg;

	// upstream command kinds
	typedef enum logic [2:0] {
		OP_NONE      = 3'd0,
		OP_ST_DISP   = 3'd1,
		OP_ST_EXEC   = 3'd2,
		OP_LD_EXEC   = 3'd3,
		OP_ST_RETIRE = 3'd4
	} mem_op_e;

	// per-entry progress of a load
	typedef enum logic [1:0] {
		LQ_WAIT = 2'd0,
		LQ_MEM  = 2'd1,
		LQ_DONE = 2'd2
	} lq_state_e;

	// store execute payload, idx carries the wrap bit too
	typedef struct packed {
		logic [lsu_params_pkg::SQ_PTR_W-1:0] idx;
		logic [lsu_params_pkg::ADDR_W-1:0]   addr;
		logic [lsu_params_pkg::DATA_W-1:0]   data;
	} st_cmd_t;

endpackage

// File: logic/sq_query_if.sv
/* age and forwarding query from the load queue to the store queue */
`timescale 1ns/1ns

interface sq_query_if #(
	parameter int unsigned SQ_DEPTH = lsu_params_pkg::SQ_DEPTH_DEF
);
	import lsu_params_pkg::*;

	logic [ADDR_W-1:0]         addr;
	// store-queue tail seen when the load was dispatched
	logic [$clog2(SQ_DEPTH):0] pos;
	logic                      older_known;
	logic                      fwd_hit;
	logic [DATA_W-1:0]         fwd_data;

	modport requester (
		output addr, pos,
		input  older_known, fwd_hit, fwd_data
	);

	modport responder (
		input  addr, pos,
		output older_known, fwd_hit, fwd_data
	);

endinterface

// File: logic/mem_op_decode.sv
/* command register and opcode decode into store and load strobes */
`timescale 1ns/1ns

module mem_op_decode (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                cmd_valid_i,
	input  lsu_types_pkg::mem_op_e              cmd_op_i,
	input  logic [lsu_params_pkg::ADDR_W-1:0]   cmd_addr_i,
	input  logic [lsu_params_pkg::DATA_W-1:0]   cmd_data_i,
	input  logic [lsu_params_pkg::SQ_PTR_W-1:0] cmd_sq_idx_i,
	input  logic [lsu_params_pkg::TAG_W-1:0]    cmd_tag_i,
	output logic                                st_disp_o,
	output logic                                st_exec_o,
	output lsu_types_pkg::st_cmd_t              st_cmd_o,
	output logic                                st_retire_o,
	output logic                                ld_exec_o,
	output logic [lsu_params_pkg::ADDR_W-1:0]   ld_addr_o,
	output logic [lsu_params_pkg::TAG_W-1:0]    ld_tag_o,
	output logic [lsu_params_pkg::SQ_PTR_W-1:0] ld_pos_o
);
	import lsu_types_pkg::*;

	// one-hot strobes, one cycle after the command
	always_ff @(posedge clk) begin
		if (rst) begin
			st_disp_o   <= 1'b0;
			st_exec_o   <= 1'b0;
			st_retire_o <= 1'b0;
			ld_exec_o   <= 1'b0;
		end else begin
			st_disp_o   <= cmd_valid_i && (cmd_op_i == OP_ST_DISP);
			st_exec_o   <= cmd_valid_i && (cmd_op_i == OP_ST_EXEC);
			st_retire_o <= cmd_valid_i && (cmd_op_i == OP_ST_RETIRE);
			ld_exec_o   <= cmd_valid_i && (cmd_op_i == OP_LD_EXEC);
		end
	end

	// fields follow their strobe, sq index doubles as load position
	always_ff @(posedge clk) begin
		if (cmd_valid_i) begin
			st_cmd_o.idx  <= cmd_sq_idx_i;
			st_cmd_o.addr <= cmd_addr_i;
			st_cmd_o.data <= cmd_data_i;
			ld_addr_o     <= cmd_addr_i;
			ld_tag_o      <= cmd_tag_i;
			ld_pos_o      <= cmd_sq_idx_i;
		end
	end

	// upstream must never send an idle or undefined opcode as valid
	a_op_known: assert property (@(posedge clk) disable iff (rst)
		cmd_valid_i |-> cmd_op_i inside {OP_ST_DISP, OP_ST_EXEC, OP_LD_EXEC, OP_ST_RETIRE});

endmodule

// File: logic/store_queue.sv
/* circular store queue with address tracking, forwarding to loads
   and in-order commit to the data memory */
`timescale 1ns/1ns

module store_queue #(
	parameter int unsigned SQ_DEPTH = lsu_params_pkg::SQ_DEPTH_DEF
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              st_disp_i,
	input  logic                              st_exec_i,
	input  lsu_types_pkg::st_cmd_t            st_cmd_i,
	input  logic                              st_retire_i,
	output logic [$clog2(SQ_DEPTH):0]         sq_tail_o,
	sq_query_if.responder                     query,
	output logic                              mem_we_o,
	output logic [lsu_params_pkg::ADDR_W-1:0] mem_waddr_o,
	output logic [lsu_params_pkg::DATA_W-1:0] mem_wdata_o
);
	import lsu_params_pkg::*;

	localparam int unsigned IW = $clog2(SQ_DEPTH);

	logic [ADDR_W-1:0]   st_addr [SQ_DEPTH];
	logic [DATA_W-1:0]   st_data [SQ_DEPTH];
	logic [SQ_DEPTH-1:0] addr_vld;
	logic [IW:0]         head;
	logic [IW:0]         tail;
	logic                full;
	logic                empty;
	logic [IW:0]         pos_diff;
	logic [IW:0]         older_cnt;
	logic [IW-1:0]       exec_idx;

	assign exec_idx  = st_cmd_i.idx[IW-1:0];
	assign full      = (head[IW] != tail[IW]) && (head[IW-1:0] == tail[IW-1:0]);
	assign empty     = (head == tail);
	// full pointer, so upstream hands loads a position with its wrap bit
	assign sq_tail_o = tail;

	// ************************************************************
	// age query
	// ************************************************************

	// stores older than the load sit in [head, pos)
	assign pos_diff = query.pos - head;
	// head already past the position means nothing older is left
	assign older_cnt = (pos_diff > SQ_DEPTH) ? '0 : pos_diff;

	// walk from oldest to youngest, last match wins
	always_comb begin
		logic [IW-1:0] ent;
		query.older_known = 1'b1;
		query.fwd_hit     = 1'b0;
		query.fwd_data    = '0;
		for (int k = 0; k < SQ_DEPTH; k++) begin
			ent = head[IW-1:0] + IW'(k);
			if (k < older_cnt) begin
				if (!addr_vld[ent]) begin
					query.older_known = 1'b0;
				end else if (st_addr[ent] == query.addr) begin
					query.fwd_hit  = 1'b1;
					query.fwd_data = st_data[ent];
				end
			end
		end
	end

	// ************************************************************
	// entries and commit
	// ************************************************************

	always_ff @(posedge clk) begin
		if (st_exec_i) begin
			st_addr[exec_idx] <= st_cmd_i.addr;
			st_data[exec_idx] <= st_cmd_i.data;
		end
		mem_waddr_o <= st_addr[head[IW-1:0]];
		mem_wdata_o <= st_data[head[IW-1:0]];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head     <= '0;
			tail     <= '0;
			addr_vld <= '0;
			mem_we_o <= 1'b0;
		end else begin
			// head entry goes to memory the cycle after retire
			mem_we_o <= st_retire_i;
			if (st_disp_i) begin
				tail                   <= tail + 1'b1;
				addr_vld[tail[IW-1:0]] <= 1'b0;
			end
			if (st_exec_i) begin
				addr_vld[exec_idx] <= 1'b1;
			end
			if (st_retire_i) begin
				head <= head + 1'b1;
			end
		end
	end

	// credits bound dispatch, retire order comes from the ROB upstream
	a_disp_not_full: assert property (@(posedge clk) disable iff (rst)
		st_disp_i |-> !full);
	a_retire_ready: assert property (@(posedge clk) disable iff (rst)
		st_retire_i |-> !empty && addr_vld[head[IW-1:0]]);

endmodule

// File: logic/load_queue.sv
/* load queue, in-order issue against older store addresses,
   forwarding or memory read, then in-order hand-off to writeback */
`timescale 1ns/1ns

module load_queue #(
	parameter int unsigned LQ_DEPTH = lsu_params_pkg::LQ_DEPTH_DEF
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                ld_exec_i,
	input  logic [lsu_params_pkg::ADDR_W-1:0]   ld_addr_i,
	input  logic [lsu_params_pkg::TAG_W-1:0]    ld_tag_i,
	input  logic [lsu_params_pkg::SQ_PTR_W-1:0] ld_pos_i,
	sq_query_if.requester                       query,
	output logic                                rd_req_o,
	output logic [lsu_params_pkg::ADDR_W-1:0]   rd_addr_o,
	input  logic                                rd_gnt_i,
	input  logic                                rd_valid_i,
	input  logic [lsu_params_pkg::DATA_W-1:0]   rd_data_i,
	output logic                                res_valid_o,
	output logic [lsu_params_pkg::TAG_W-1:0]    res_tag_o,
	output logic [lsu_params_pkg::DATA_W-1:0]   res_data_o,
	input  logic                                res_ready_i
);
	import lsu_params_pkg::*;
	import lsu_types_pkg::*;

	localparam int unsigned IW = $clog2(LQ_DEPTH);

	lq_state_e         state  [LQ_DEPTH];
	logic [ADDR_W-1:0] addr_q [LQ_DEPTH];
	logic [TAG_W-1:0]  tag_q  [LQ_DEPTH];
	logic [SQ_PTR_W-1:0] pos_q [LQ_DEPTH];
	logic [DATA_W-1:0] data_q [LQ_DEPTH];
	// head..iss issued, iss..tail still waiting
	logic [IW:0]       head;
	logic [IW:0]       iss;
	logic [IW:0]       tail;
	logic [IW-1:0]     rd_idx;
	logic              rd_busy;
	logic              full;
	logic              iss_ready;
	logic              fwd_take;
	logic              res_take;

	assign full = (head[IW] != tail[IW]) && (head[IW-1:0] == tail[IW-1:0]);

	// oldest waiting load asks the store queue
	assign query.addr = addr_q[iss[IW-1:0]];
	assign query.pos  = pos_q[iss[IW-1:0]];
	assign iss_ready  = (iss != tail) && query.older_known;
	assign fwd_take   = iss_ready && query.fwd_hit;

	// one memory read outstanding at a time
	assign rd_req_o  = iss_ready && !query.fwd_hit && !rd_busy;
	assign rd_addr_o = query.addr;

	assign res_valid_o = (head != iss) && (state[head[IW-1:0]] == LQ_DONE);
	assign res_tag_o   = tag_q[head[IW-1:0]];
	assign res_data_o  = data_q[head[IW-1:0]];
	assign res_take    = res_valid_o && res_ready_i;

	always_ff @(posedge clk) begin
		if (ld_exec_i) begin
			addr_q[tail[IW-1:0]] <= ld_addr_i;
			tag_q[tail[IW-1:0]]  <= ld_tag_i;
			pos_q[tail[IW-1:0]]  <= ld_pos_i;
		end
		if (fwd_take) begin
			data_q[iss[IW-1:0]] <= query.fwd_data;
		end
		if (rd_valid_i) begin
			data_q[rd_idx] <= rd_data_i;
		end
		if (rd_gnt_i) begin
			rd_idx <= iss[IW-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head    <= '0;
			iss     <= '0;
			tail    <= '0;
			rd_busy <= 1'b0;
			for (int k = 0; k < LQ_DEPTH; k++) begin
				state[k] <= LQ_WAIT;
			end
		end else begin
			if (ld_exec_i) begin
				tail                <= tail + 1'b1;
				state[tail[IW-1:0]] <= LQ_WAIT;
			end
			if (fwd_take) begin
				state[iss[IW-1:0]] <= LQ_DONE;
				iss                <= iss + 1'b1;
			end else if (rd_gnt_i) begin
				state[iss[IW-1:0]] <= LQ_MEM;
				iss                <= iss + 1'b1;
			end
			if (rd_gnt_i) begin
				rd_busy <= 1'b1;
			end else if (rd_valid_i) begin
				rd_busy <= 1'b0;
			end
			if (rd_valid_i) begin
				state[rd_idx] <= LQ_DONE;
			end
			if (res_take) begin
				head <= head + 1'b1;
			end
		end
	end

	a_ld_not_full: assert property (@(posedge clk) disable iff (rst)
		ld_exec_i |-> !full);
	// memory answers a grant two cycles later, into the entry waiting for it
	a_rd_return: assert property (@(posedge clk) disable iff (rst)
		rd_gnt_i |-> ##2 (rd_valid_i && state[rd_idx] == LQ_MEM));

endmodule

// File: logic/data_mem.sv
/* word memory with commit-first arbitration and a two-stage read */
`timescale 1ns/1ns

module data_mem #(
	parameter int unsigned MEM_WORDS = 64
) (
	input  logic                              clk,
	input  logic                              we_i,
	input  logic [lsu_params_pkg::ADDR_W-1:0] waddr_i,
	input  logic [lsu_params_pkg::DATA_W-1:0] wdata_i,
	output logic                              commit_done_o,
	input  logic                              rd_req_i,
	input  logic [lsu_params_pkg::ADDR_W-1:0] rd_addr_i,
	output logic                              rd_gnt_o,
	output logic                              rd_valid_o,
	output logic [lsu_params_pkg::DATA_W-1:0] rd_data_o
);
	import lsu_params_pkg::*;

	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic              rd_v1;
	logic [DATA_W-1:0] rd_d1;

	// a commit owns the port for its cycle
	assign rd_gnt_o = rd_req_i && !we_i;

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
		commit_done_o <= we_i;
		// stage 1 array read, stage 2 output register
		rd_v1      <= rd_gnt_o;
		rd_d1      <= mem[rd_addr_i];
		rd_valid_o <= rd_v1;
		rd_data_o  <= rd_d1;
	end

endmodule

// File: logic/load_result.sv
/* writeback register for load results and load credit return */
`timescale 1ns/1ns

module load_result (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              res_valid_i,
	input  logic [lsu_params_pkg::TAG_W-1:0]  res_tag_i,
	input  logic [lsu_params_pkg::DATA_W-1:0] res_data_i,
	output logic                              res_ready_o,
	output logic                              wb_valid_o,
	output logic [lsu_params_pkg::TAG_W-1:0]  wb_tag_o,
	output logic [lsu_params_pkg::DATA_W-1:0] wb_data_o,
	output logic                              lq_credit_o
);
	logic take;

	// nothing stalls the writeback, the register drains every cycle
	assign res_ready_o = 1'b1;
	assign take        = res_valid_i && res_ready_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid_o  <= 1'b0;
			lq_credit_o <= 1'b0;
		end else begin
			wb_valid_o  <= take;
			// the load-queue slot is already free once accepted
			lq_credit_o <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			wb_tag_o  <= res_tag_i;
			wb_data_o <= res_data_i;
		end
	end

endmodule

// File: logic/lsu_top.sv
/* load/store unit top: decode, store and load queues,
   data memory and result writeback */
`timescale 1ns/1ns

module lsu_top #(
	parameter int unsigned SQ_DEPTH = lsu_params_pkg::SQ_DEPTH_DEF,
	parameter int unsigned LQ_DEPTH = lsu_params_pkg::LQ_DEPTH_DEF
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                cmd_valid_i,
	input  lsu_types_pkg::mem_op_e              cmd_op_i,
	input  logic [lsu_params_pkg::ADDR_W-1:0]   cmd_addr_i,
	input  logic [lsu_params_pkg::DATA_W-1:0]   cmd_data_i,
	input  logic [lsu_params_pkg::SQ_PTR_W-1:0] cmd_sq_idx_i,
	input  logic [lsu_params_pkg::TAG_W-1:0]    cmd_tag_i,
	output logic [$clog2(SQ_DEPTH):0]           sq_tail_o,
	output logic                                sq_credit_o,
	output logic                                lq_credit_o,
	output logic                                wb_valid_o,
	output logic [lsu_params_pkg::TAG_W-1:0]    wb_tag_o,
	output logic [lsu_params_pkg::DATA_W-1:0]   wb_data_o
);
	import lsu_params_pkg::*;
	import lsu_types_pkg::*;

	// decode to queues
	logic              st_disp;
	logic              st_exec;
	logic              st_retire;
	st_cmd_t           st_cmd;
	logic              ld_exec;
	logic [ADDR_W-1:0] ld_addr;
	logic [TAG_W-1:0]  ld_tag;
	logic [SQ_PTR_W-1:0] ld_pos;

	// queues to memory
	logic              mem_we;
	logic [ADDR_W-1:0] mem_waddr;
	logic [DATA_W-1:0] mem_wdata;
	logic              rd_req;
	logic [ADDR_W-1:0] rd_addr;
	logic              rd_gnt;
	logic              rd_valid;
	logic [DATA_W-1:0] rd_data;

	// load queue to writeback
	logic              res_valid;
	logic [TAG_W-1:0]  res_tag;
	logic [DATA_W-1:0] res_data;
	logic              res_ready;

	sq_query_if #(.SQ_DEPTH(SQ_DEPTH)) sq_query ();

	mem_op_decode decode (
		.clk, .rst,
		.cmd_valid_i, .cmd_op_i, .cmd_addr_i, .cmd_data_i, .cmd_sq_idx_i, .cmd_tag_i,
		.st_disp_o(st_disp), .st_exec_o(st_exec), .st_cmd_o(st_cmd),
		.st_retire_o(st_retire), .ld_exec_o(ld_exec), .ld_addr_o(ld_addr),
		.ld_tag_o(ld_tag), .ld_pos_o(ld_pos)
	);

	store_queue #(.SQ_DEPTH(SQ_DEPTH)) execute_sq (
		.clk, .rst,
		.st_disp_i(st_disp), .st_exec_i(st_exec), .st_cmd_i(st_cmd),
		.st_retire_i(st_retire), .sq_tail_o, .query(sq_query.responder),
		.mem_we_o(mem_we), .mem_waddr_o(mem_waddr), .mem_wdata_o(mem_wdata)
	);

	load_queue #(.LQ_DEPTH(LQ_DEPTH)) execute_lq (
		.clk, .rst,
		.ld_exec_i(ld_exec), .ld_addr_i(ld_addr), .ld_tag_i(ld_tag), .ld_pos_i(ld_pos),
		.query(sq_query.requester),
		.rd_req_o(rd_req), .rd_addr_o(rd_addr), .rd_gnt_i(rd_gnt),
		.rd_valid_i(rd_valid), .rd_data_i(rd_data),
		.res_valid_o(res_valid), .res_tag_o(res_tag), .res_data_o(res_data),
		.res_ready_i(res_ready)
	);

	// store credit is the commit acknowledge
	data_mem #(.MEM_WORDS(64)) dmem (
		.clk,
		.we_i(mem_we), .waddr_i(mem_waddr), .wdata_i(mem_wdata),
		.commit_done_o(sq_credit_o),
		.rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_gnt_o(rd_gnt),
		.rd_valid_o(rd_valid), .rd_data_o(rd_data)
	);

	load_result result (
		.clk, .rst,
		.res_valid_i(res_valid), .res_tag_i(res_tag), .res_data_i(res_data),
		.res_ready_o(res_ready),
		.wb_valid_o, .wb_tag_o, .wb_data_o, .lq_credit_o
	);

endmodule

// File: dv/lsu_tb.sv
/* load/store unit testbench: replays a command file under credit rules,
   scores load writebacks by tag and checks the credit totals */
`timescale 1ns/1ns

module lsu_tb;
	import lsu_params_pkg::*;
	import lsu_types_pkg::*;

	localparam int unsigned SQ_DEPTH   = SQ_DEPTH_DEF;
	localparam int unsigned LQ_DEPTH   = LQ_DEPTH_DEF;
	localparam int          MAX_CASES  = 64;
	localparam int          WAIT_LIMIT = 300;
	localparam int          NUM_TAGS   = 2 ** TAG_W;
	// conditions a wait loop can wait for
	localparam int          W_SQ_CREDIT = 0;
	localparam int          W_LQ_CREDIT = 1;
	localparam int          W_COMMITS   = 2;
	localparam int          W_WBACKS    = 3;

	logic                clk;
	logic                rst;
	logic                cmd_valid;
	mem_op_e             cmd_op;
	logic [ADDR_W-1:0]   cmd_addr;
	logic [DATA_W-1:0]   cmd_data;
	logic [SQ_PTR_W-1:0] cmd_sq_idx;
	logic [TAG_W-1:0]    cmd_tag;
	logic [SQ_PTR_W-1:0] sq_tail;
	logic                sq_credit;
	logic                lq_credit;
	logic                wb_valid;
	logic [TAG_W-1:0]    wb_tag;
	logic [DATA_W-1:0]   wb_data;

	// six words per case line
	logic [31:0]         case_words [6*MAX_CASES];
	// scoreboard by destination tag
	logic [DATA_W-1:0]   exp_data [NUM_TAGS];
	int                  exp_name [NUM_TAGS];
	bit                  pending  [NUM_TAGS];
	// store number to store-queue index with wrap bit
	logic [SQ_PTR_W-1:0] st_idx   [NUM_TAGS];
	logic [SQ_PTR_W-1:0] tb_tail;
	int                  st_count;
	int                  sq_credits;
	int                  lq_credits;
	int                  sq_pulses;
	int                  lq_pulses;
	int                  retire_sent;
	int                  ld_sent;
	int                  wb_count;
	int                  data_errs;
	int                  count_errs;
	int                  tag_errs;
	int                  wait_errs;
	bit                  timed_out;
	bit                  finished;

	lsu_top #(.SQ_DEPTH(SQ_DEPTH), .LQ_DEPTH(LQ_DEPTH)) dut (
		.clk, .rst,
		.cmd_valid_i(cmd_valid), .cmd_op_i(cmd_op), .cmd_addr_i(cmd_addr),
		.cmd_data_i(cmd_data), .cmd_sq_idx_i(cmd_sq_idx), .cmd_tag_i(cmd_tag),
		.sq_tail_o(sq_tail), .sq_credit_o(sq_credit), .lq_credit_o(lq_credit),
		.wb_valid_o(wb_valid), .wb_tag_o(wb_tag), .wb_data_o(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ************************************************************
	// compare tasks
	// ************************************************************

	task automatic check_data(input string name, input logic [DATA_W-1:0] exp_v,
			input logic [DATA_W-1:0] act_v);
		if (act_v !== exp_v) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
			data_errs++;
		end
	endtask

	task automatic check_count(input string name, input int exp_v, input int act_v);
		if (act_v != exp_v) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp_v, act_v);
			count_errs++;
		end
	endtask

	task automatic check_tag(input logic [TAG_W-1:0] tag);
		if (!pending[tag]) begin
			$display("writeback carries tag %0d but no load with that tag is pending", tag);
			tag_errs++;
		end
	endtask

	function automatic string test_name(input int idx);
		case (idx)
			0: return "fwd_single";
			1: return "fwd_youngest";
			2: return "mem_commit";
			3: return "older_load";
			4: return "wait_addr";
			5: return "fill_drain";
			default: return "unnamed";
		endcase
	endfunction

	// credits and results, sampled before the edge updates them
	always @(posedge clk) begin
		if (!rst) begin
			if (sq_credit) begin
				sq_credits++;
				sq_pulses++;
			end
			if (lq_credit) begin
				lq_credits++;
				lq_pulses++;
			end
			if (wb_valid) begin
				wb_count++;
				check_tag(wb_tag);
				if (pending[wb_tag]) begin
					check_data(test_name(exp_name[wb_tag]), exp_data[wb_tag], wb_data);
					pending[wb_tag] = 1'b0;
				end
			end
		end
	end

	// ************************************************************
	// command driving
	// ************************************************************

	function automatic bit ready_for(input int what);
		case (what)
			W_SQ_CREDIT: return sq_credits > 0;
			W_LQ_CREDIT: return lq_credits > 0;
			W_COMMITS:   return sq_pulses == retire_sent;
			default:     return wb_count == ld_sent;
		endcase
	endfunction

	task automatic wait_for(input int what, input string what_txt);
		int n;
		n = 0;
		while (!ready_for(what) && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!ready_for(what)) begin
			$display("timed out after %0d cycles waiting for %s", WAIT_LIMIT, what_txt);
			wait_errs++;
			timed_out = 1'b1;
		end
	endtask

	task automatic send_cmd(input mem_op_e op, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data, input logic [SQ_PTR_W-1:0] idx,
			input logic [TAG_W-1:0] tag);
		int idle;
		cmd_valid  = 1'b1;
		cmd_op     = op;
		cmd_addr   = addr;
		cmd_data   = data;
		cmd_sq_idx = idx;
		cmd_tag    = tag;
		@(negedge clk);
		cmd_valid = 1'b0;
		cmd_op    = OP_NONE;
		idle      = $urandom % 3;
		repeat (idle) @(negedge clk);
	endtask

	task automatic dispatch_store();
		st_idx[st_count[TAG_W-1:0]] = tb_tail;
		sq_credits--;
		send_cmd(OP_ST_DISP, '0, '0, tb_tail, '0);
		tb_tail  = tb_tail + 1'b1;
		st_count++;
	endtask

	task automatic issue_load(input logic [ADDR_W-1:0] addr, input logic [TAG_W-1:0] tag,
			input int name, input logic [DATA_W-1:0] exp_v);
		if (pending[tag]) begin
			$display("tag %0d reused while its load is still pending", tag);
			tag_errs++;
		end
		exp_data[tag] = exp_v;
		exp_name[tag] = name;
		pending[tag]  = 1'b1;
		lq_credits--;
		ld_sent++;
		// position is the store tail right now, so older stores precede it
		send_cmd(OP_LD_EXEC, addr, '0, tb_tail, tag);
	endtask

	task automatic run_case(input int i);
		logic [3:0]        op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [TAG_W-1:0]  tag;
		int                name;
		logic [DATA_W-1:0] exp_v;
		op    = case_words[6*i][3:0];
		addr  = case_words[6*i+1][ADDR_W-1:0];
		data  = case_words[6*i+2];
		tag   = case_words[6*i+3][TAG_W-1:0];
		name  = int'(case_words[6*i+4]);
		exp_v = case_words[6*i+5];
		case (op)
			4'h1: for (int n = 0; n < int'(data) && !timed_out; n++) begin
				wait_for(W_SQ_CREDIT, "a store credit");
				if (!timed_out) begin
					dispatch_store();
				end
			end
			4'h2: send_cmd(OP_ST_EXEC, addr, data, st_idx[tag], '0);
			4'h3: begin
				wait_for(W_LQ_CREDIT, "a load credit");
				if (!timed_out) begin
					issue_load(addr, tag, name, exp_v);
				end
			end
			4'h4: for (int n = 0; n < int'(data); n++) begin
				retire_sent++;
				send_cmd(OP_ST_RETIRE, '0, '0, '0, '0);
			end
			4'hd: wait_for(W_COMMITS, "store commits");
			4'he: wait_for(W_WBACKS, "load writebacks");
			4'hf: finished = 1'b1;
			default: @(negedge clk);
		endcase
	endtask

	initial begin
		int i;
		void'($urandom(23263));
		rst        = 1'b1;
		cmd_valid  = 1'b0;
		cmd_op     = OP_NONE;
		cmd_addr   = '0;
		cmd_data   = '0;
		cmd_sq_idx = '0;
		cmd_tag    = '0;
		tb_tail    = '0;
		sq_credits = SQ_DEPTH;
		lq_credits = LQ_DEPTH;
		for (int t = 0; t < NUM_TAGS; t++) begin
			pending[t] = 1'b0;
		end
		$readmemh("dv/lsu_cases.txt", case_words);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		i = 0;
		while (!finished && !timed_out && i < MAX_CASES) begin
			run_case(i);
			i++;
		end
		if (!timed_out) begin
			wait_for(W_WBACKS, "the final load writebacks");
		end
		if (!timed_out) begin
			wait_for(W_COMMITS, "the final store commits");
		end
		if (!timed_out) begin
			// late or extra pulses would show up here
			repeat (10) @(negedge clk);
			check_count("store credits", SQ_DEPTH, sq_credits);
			check_count("load credits", LQ_DEPTH, lq_credits);
			check_count("store credit pulses", retire_sent, sq_pulses);
			check_count("load credit pulses", ld_sent, lq_pulses);
			check_count("writebacks", ld_sent, wb_count);
			check_count("store queue tail", int'(tb_tail), int'(sq_tail));
			for (int t = 0; t < NUM_TAGS; t++) begin
				if (pending[t]) begin
					$display("load with tag %0d was never written back", t);
					tag_errs++;
				end
			end
		end

		$display("errors: %0d data, %0d count, %0d tag, %0d wait",
			data_errs, count_errs, tag_errs, wait_errs);
		if (data_errs + count_errs + tag_errs + wait_errs == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: dv/lsu_cases.txt
// columns in hex: op addr data tag name expected; op 1 and 4 repeat data times
// op 1 st disp, 2 st exec (tag = store number), 3 load, 4 retire, d commits, e writebacks, f end
1 00 00000001 00 0 00000000
2 10 11111111 00 0 00000000
3 10 00000000 01 0 11111111
1 00 00000002 00 0 00000000
2 10 22222222 01 0 00000000
2 10 33333333 02 0 00000000
3 10 00000000 02 1 33333333
e 00 00000000 00 0 00000000
4 00 00000003 00 0 00000000
d 00 00000000 00 0 00000000
3 10 00000000 03 2 33333333
3 10 00000000 04 3 33333333
1 00 00000001 00 0 00000000
2 10 44444444 03 0 00000000
e 00 00000000 00 0 00000000
4 00 00000001 00 0 00000000
d 00 00000000 00 0 00000000
3 10 00000000 05 2 44444444
1 00 00000001 00 0 00000000
3 20 00000000 06 4 55555555
2 20 55555555 04 0 00000000
e 00 00000000 00 0 00000000
4 00 00000001 00 0 00000000
d 00 00000000 00 0 00000000
1 00 00000008 00 0 00000000
3 30 00000000 07 5 abcd000c
3 31 00000000 08 5 abcd0006
3 10 00000000 09 5 44444444
3 37 00000000 0a 5 abcd000b
2 30 abcd0005 05 0 00000000
2 31 abcd0006 06 0 00000000
2 32 abcd0007 07 0 00000000
2 33 abcd0008 08 0 00000000
2 34 abcd0009 09 0 00000000
2 35 abcd000a 0a 0 00000000
2 37 abcd000b 0b 0 00000000
2 30 abcd000c 0c 0 00000000
e 00 00000000 00 0 00000000
4 00 00000008 00 0 00000000
d 00 00000000 00 0 00000000
f 00 00000000 00 0 00000000

// File: list.f
logic/lsu_params_pkg.sv
logic/lsu_types_pkg.sv
logic/sq_query_if.sv
logic/mem_op_decode.sv
logic/store_queue.sv
logic/load_queue.sv
logic/data_mem.sv
logic/load_result.sv
logic/lsu_top.sv
dv/lsu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module lsu_tb -f list.f -o lsu_sim

# the log decides the result, not the simulator exit status
./obj_dir/lsu_sim | tee sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
	echo "result: pass"
else
	echo "result: fail"
	exit 1
fi
